// File: rtl/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// ----------------------------------------------------------------------
// datapath sizing.
// ----------------------------------------------------------------------

// data word and program counter width.
`define CPU_WORD 16

// register address width.
`define CPU_ADDR_WIDTH 3

// general registers, must match the address width.
`define CPU_NUM_REGS 8

`endif

// File: rtl/cpu_isa_pkg.sv
`default_nettype none

`include "cpu_config.svh"

package cpu_isa_pkg;

  // ----------------------------------------------------------------------
  // opcodes.
  // ----------------------------------------------------------------------
  typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_AND  = 4'd3,
    OP_OR   = 4'd4,
    OP_XOR  = 4'd5,
    OP_ADD3 = 4'd6,
    OP_ADDI = 4'd7,
    OP_MOVI = 4'd8,
    OP_CMP  = 4'd9
  } opcode_e;

  // ----------------------------------------------------------------------
  // instruction word.
  // ----------------------------------------------------------------------
  // tail holds rs2/rs3 for register ops.
  // ADDI reads it as a signed 6-bit immediate.
  // MOVI takes {rs1[1:0], tail} as an 8-bit value.
  typedef struct packed {
    opcode_e                     opcode;
    logic [`CPU_ADDR_WIDTH-1:0]  rd;
    logic [`CPU_ADDR_WIDTH-1:0]  rs1;
    logic [5:0]                  tail;
  } instruction_t;

endpackage

`default_nettype wire

// File: rtl/cpu_ctrl_pkg.sv
`default_nettype none

`include "cpu_config.svh"

package cpu_ctrl_pkg;

  // ----------------------------------------------------------------------
  // alu and operand selection.
  // ----------------------------------------------------------------------
  typedef enum logic [2:0] {
    ALU_PASS_B = 3'd0,
    ALU_ADD    = 3'd1,
    ALU_SUB    = 3'd2,
    ALU_AND    = 3'd3,
    ALU_OR     = 3'd4,
    ALU_XOR    = 3'd5
  } alu_op_e;

  typedef enum logic [1:0] {
    SRC_REG     = 2'd0,
    SRC_IMM     = 2'd1,
    SRC_ACC_IMM = 2'd2
  } alu_src_e;

  // decoded control, carried through the pipeline register.
  typedef struct packed {
    logic      rf_write;
    alu_src_e  alu_src_b;
    alu_op_e   alu_op;
    logic      update_flags;
    logic      use_rs3;
  } ctrl_t;

  // ----------------------------------------------------------------------
  // execute outputs.
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic  zero;
    logic  negative;
    logic  carry;
  } flags_t;

  typedef struct packed {
    logic                        valid;
    logic                        rf_write;
    logic [`CPU_ADDR_WIDTH-1:0]  dest;
    logic [`CPU_WORD-1:0]        data;
    logic [`CPU_WORD-1:0]        pc;
  } wb_result_t;

endpackage

`default_nettype wire

// File: rtl/instruction_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module instruction_decoder (
  input  cpu_isa_pkg::instruction_t    instr_i,
  output cpu_ctrl_pkg::ctrl_t          ctrl_o,
  output logic [`CPU_ADDR_WIDTH-1:0]   rs1_o,
  output logic [`CPU_ADDR_WIDTH-1:0]   rs2_o,
  output logic [`CPU_ADDR_WIDTH-1:0]   rs3_o,
  output logic [`CPU_ADDR_WIDTH-1:0]   rd_o,
  output logic [`CPU_WORD-1:0]         imm_o,
  output logic [`CPU_WORD-1:0]         acc_imm_o
);

  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;

  // ----------------------------------------------------------------------
  // field extraction.
  // ----------------------------------------------------------------------
  assign rs1_o = instr_i.rs1;
  assign rs2_o = instr_i.tail[5:3];
  assign rs3_o = instr_i.tail[2:0];
  assign rd_o  = instr_i.rd;

  // sign-extended for ADDI.
  assign imm_o = {{(`CPU_WORD-6){instr_i.tail[5]}}, instr_i.tail};

  // low rs1 bits extend the tail to 8 bits.
  assign acc_imm_o = {{(`CPU_WORD-8){1'b0}}, instr_i.rs1[1:0], instr_i.tail};

  // ----------------------------------------------------------------------
  // control.
  // ----------------------------------------------------------------------
  always_comb begin
    ctrl_o              = '0;
    ctrl_o.alu_src_b    = SRC_REG;
    ctrl_o.alu_op       = ALU_PASS_B;

    case (instr_i.opcode)
      OP_ADD, OP_ADD3: begin
        ctrl_o.rf_write     = 1'b1;
        ctrl_o.alu_op       = ALU_ADD;
        ctrl_o.update_flags = 1'b1;
        ctrl_o.use_rs3      = (instr_i.opcode == OP_ADD3);
      end
      OP_SUB, OP_CMP: begin
        // compare only keeps the flags.
        ctrl_o.rf_write     = (instr_i.opcode == OP_SUB);
        ctrl_o.alu_op       = ALU_SUB;
        ctrl_o.update_flags = 1'b1;
      end
      OP_AND: begin
        ctrl_o.rf_write     = 1'b1;
        ctrl_o.alu_op       = ALU_AND;
        ctrl_o.update_flags = 1'b1;
      end
      OP_OR: begin
        ctrl_o.rf_write     = 1'b1;
        ctrl_o.alu_op       = ALU_OR;
        ctrl_o.update_flags = 1'b1;
      end
      OP_XOR: begin
        ctrl_o.rf_write     = 1'b1;
        ctrl_o.alu_op       = ALU_XOR;
        ctrl_o.update_flags = 1'b1;
      end
      OP_ADDI: begin
        ctrl_o.rf_write     = 1'b1;
        ctrl_o.alu_src_b    = SRC_IMM;
        ctrl_o.alu_op       = ALU_ADD;
        ctrl_o.update_flags = 1'b1;
      end
      OP_MOVI: begin
        ctrl_o.rf_write     = 1'b1;
        ctrl_o.alu_src_b    = SRC_ACC_IMM;
      end
      default: begin
        // NOP and unused encodings do nothing.
        ctrl_o.rf_write     = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/decode_execution_register.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module decode_execution_register (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        flush_i,
  input  logic                        valid_i,
  input  cpu_ctrl_pkg::ctrl_t         ctrl_i,
  input  logic [`CPU_ADDR_WIDTH-1:0]  rs1_i,
  input  logic [`CPU_ADDR_WIDTH-1:0]  rs2_i,
  input  logic [`CPU_ADDR_WIDTH-1:0]  rs3_i,
  input  logic [`CPU_ADDR_WIDTH-1:0]  rd_i,
  input  logic [`CPU_WORD-1:0]        imm_i,
  input  logic [`CPU_WORD-1:0]        acc_imm_i,
  input  logic [`CPU_WORD-1:0]        pc_i,

  output logic                        valid_o,
  output cpu_ctrl_pkg::ctrl_t         ctrl_o,
  output logic [`CPU_ADDR_WIDTH-1:0]  rs1_o,
  output logic [`CPU_ADDR_WIDTH-1:0]  rs2_o,
  output logic [`CPU_ADDR_WIDTH-1:0]  rs3_o,
  output logic [`CPU_ADDR_WIDTH-1:0]  rd_o,
  output logic [`CPU_WORD-1:0]        imm_o,
  output logic [`CPU_WORD-1:0]        acc_imm_o,
  output logic [`CPU_WORD-1:0]        pc_o
);

  // reset first, then flush.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o <= 1'b0;
    end else if (flush_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // payload follows decode every cycle.
  always_ff @(posedge clk_i) begin
    ctrl_o    <= ctrl_i;
    rs1_o     <= rs1_i;
    rs2_o     <= rs2_i;
    rs3_o     <= rs3_i;
    rd_o      <= rd_i;
    imm_o     <= imm_i;
    acc_imm_o <= acc_imm_i;
    pc_o      <= pc_i;
  end

endmodule

`default_nettype wire

// File: rtl/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module register_file (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic [`CPU_ADDR_WIDTH-1:0]  raddr1_i,
  input  logic [`CPU_ADDR_WIDTH-1:0]  raddr2_i,
  input  logic [`CPU_ADDR_WIDTH-1:0]  raddr3_i,
  output logic [`CPU_WORD-1:0]        rdata1_o,
  output logic [`CPU_WORD-1:0]        rdata2_o,
  output logic [`CPU_WORD-1:0]        rdata3_o,
  input  logic                        we_i,
  input  logic [`CPU_ADDR_WIDTH-1:0]  waddr_i,
  input  logic [`CPU_WORD-1:0]        wdata_i
);

  logic [`CPU_WORD-1:0] regs [`CPU_NUM_REGS];

  // asynchronous reads.
  assign rdata1_o = regs[raddr1_i];
  assign rdata2_o = regs[raddr2_i];
  assign rdata3_o = regs[raddr3_i];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `CPU_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i) begin
      regs[waddr_i] <= wdata_i;
    end
  end

endmodule

`default_nettype wire

// File: rtl/alu_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module alu_execute (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        valid_i,
  input  cpu_ctrl_pkg::ctrl_t         ctrl_i,
  input  logic [`CPU_ADDR_WIDTH-1:0]  rd_i,
  input  logic [`CPU_WORD-1:0]        imm_i,
  input  logic [`CPU_WORD-1:0]        acc_imm_i,
  input  logic [`CPU_WORD-1:0]        pc_i,
  input  logic [`CPU_WORD-1:0]        rdata1_i,
  input  logic [`CPU_WORD-1:0]        rdata2_i,
  input  logic [`CPU_WORD-1:0]        rdata3_i,
  output logic                        rf_we_o,
  output logic [`CPU_ADDR_WIDTH-1:0]  rf_waddr_o,
  output logic [`CPU_WORD-1:0]        rf_wdata_o,
  output cpu_ctrl_pkg::wb_result_t    result_o,
  output cpu_ctrl_pkg::flags_t        flags_o
);

  import cpu_ctrl_pkg::*;

  logic [`CPU_WORD-1:0]  operand_b;
  logic [`CPU_WORD:0]    alu_wide;
  flags_t                alu_flags;
  logic                  retire;

  // ----------------------------------------------------------------------
  // operand b and alu.
  // ----------------------------------------------------------------------
  always_comb begin
    case (ctrl_i.alu_src_b)
      SRC_IMM:     operand_b = imm_i;
      SRC_ACC_IMM: operand_b = acc_imm_i;
      default:     operand_b = ctrl_i.use_rs3 ? rdata3_i : rdata2_i;
    endcase
  end

  // top bit is carry on add, borrow on sub.
  always_comb begin
    case (ctrl_i.alu_op)
      ALU_ADD: alu_wide = {1'b0, rdata1_i} + {1'b0, operand_b};
      ALU_SUB: alu_wide = {1'b0, rdata1_i} - {1'b0, operand_b};
      ALU_AND: alu_wide = {1'b0, rdata1_i & operand_b};
      ALU_OR:  alu_wide = {1'b0, rdata1_i | operand_b};
      ALU_XOR: alu_wide = {1'b0, rdata1_i ^ operand_b};
      default: alu_wide = {1'b0, operand_b};
    endcase
  end

  assign alu_flags.zero     = (alu_wide[`CPU_WORD-1:0] == '0);
  assign alu_flags.negative = alu_wide[`CPU_WORD-1];
  assign alu_flags.carry    = alu_wide[`CPU_WORD];

  // ----------------------------------------------------------------------
  // writeback.
  // ----------------------------------------------------------------------
  // lands on the edge that closes execute.
  assign rf_we_o    = valid_i & ctrl_i.rf_write;
  assign rf_waddr_o = rd_i;
  assign rf_wdata_o = alu_wide[`CPU_WORD-1:0];

  // nop retires without a result.
  assign retire = valid_i & (ctrl_i.rf_write | ctrl_i.update_flags);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      flags_o <= '0;
    end else if (valid_i && ctrl_i.update_flags) begin
      flags_o <= alu_flags;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      result_o.valid    <= 1'b0;
      result_o.rf_write <= 1'b0;
    end else begin
      result_o.valid    <= retire;
      result_o.rf_write <= valid_i & ctrl_i.rf_write;
    end
    result_o.dest <= rd_i;
    result_o.data <= alu_wide[`CPU_WORD-1:0];
    result_o.pc   <= pc_i;
  end

endmodule

`default_nettype wire

// File: rtl/decode_execute_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module decode_execute_core (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      instr_valid_i,
  input  cpu_isa_pkg::instruction_t instr_i,
  input  logic [`CPU_WORD-1:0]      pc_i,
  input  logic                      flush_i,
  output cpu_ctrl_pkg::wb_result_t  result_o,
  output cpu_ctrl_pkg::flags_t      flags_o
);

  import cpu_ctrl_pkg::*;

  // ----------------------------------------------------------------------
  // decode stage.
  // ----------------------------------------------------------------------
  ctrl_t                       decode_ctrl;
  logic [`CPU_ADDR_WIDTH-1:0]  decode_rs1;
  logic [`CPU_ADDR_WIDTH-1:0]  decode_rs2;
  logic [`CPU_ADDR_WIDTH-1:0]  decode_rs3;
  logic [`CPU_ADDR_WIDTH-1:0]  decode_rd;
  logic [`CPU_WORD-1:0]        decode_imm;
  logic [`CPU_WORD-1:0]        decode_acc_imm;

  // execute stage.
  logic                        ex_valid;
  ctrl_t                       ex_ctrl;
  logic [`CPU_ADDR_WIDTH-1:0]  ex_rs1;
  logic [`CPU_ADDR_WIDTH-1:0]  ex_rs2;
  logic [`CPU_ADDR_WIDTH-1:0]  ex_rs3;
  logic [`CPU_ADDR_WIDTH-1:0]  ex_rd;
  logic [`CPU_WORD-1:0]        ex_imm;
  logic [`CPU_WORD-1:0]        ex_acc_imm;
  logic [`CPU_WORD-1:0]        ex_pc;
  logic [`CPU_WORD-1:0]        rdata1;
  logic [`CPU_WORD-1:0]        rdata2;
  logic [`CPU_WORD-1:0]        rdata3;

  // register file write port.
  logic                        rf_we;
  logic [`CPU_ADDR_WIDTH-1:0]  rf_waddr;
  logic [`CPU_WORD-1:0]        rf_wdata;

  instruction_decoder u_decoder (
    .instr_i   (instr_i),
    .ctrl_o    (decode_ctrl),
    .rs1_o     (decode_rs1),
    .rs2_o     (decode_rs2),
    .rs3_o     (decode_rs3),
    .rd_o      (decode_rd),
    .imm_o     (decode_imm),
    .acc_imm_o (decode_acc_imm)
  );

  decode_execution_register u_de_reg (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .flush_i   (flush_i),
    .valid_i   (instr_valid_i),
    .ctrl_i    (decode_ctrl),
    .rs1_i     (decode_rs1),
    .rs2_i     (decode_rs2),
    .rs3_i     (decode_rs3),
    .rd_i      (decode_rd),
    .imm_i     (decode_imm),
    .acc_imm_i (decode_acc_imm),
    .pc_i      (pc_i),
    .valid_o   (ex_valid),
    .ctrl_o    (ex_ctrl),
    .rs1_o     (ex_rs1),
    .rs2_o     (ex_rs2),
    .rs3_o     (ex_rs3),
    .rd_o      (ex_rd),
    .imm_o     (ex_imm),
    .acc_imm_o (ex_acc_imm),
    .pc_o      (ex_pc)
  );

  // ----------------------------------------------------------------------
  // execute stage.
  // ----------------------------------------------------------------------
  register_file u_regs (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .raddr1_i (ex_rs1),
    .raddr2_i (ex_rs2),
    .raddr3_i (ex_rs3),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .rdata3_o (rdata3),
    .we_i     (rf_we),
    .waddr_i  (rf_waddr),
    .wdata_i  (rf_wdata)
  );

  alu_execute u_execute (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .valid_i    (ex_valid),
    .ctrl_i     (ex_ctrl),
    .rd_i       (ex_rd),
    .imm_i      (ex_imm),
    .acc_imm_i  (ex_acc_imm),
    .pc_i       (ex_pc),
    .rdata1_i   (rdata1),
    .rdata2_i   (rdata2),
    .rdata3_i   (rdata3),
    .rf_we_o    (rf_we),
    .rf_waddr_o (rf_waddr),
    .rf_wdata_o (rf_wdata),
    .result_o   (result_o),
    .flags_o    (flags_o)
  );

endmodule

`default_nettype wire

// File: test/decode_execute_core_properties.sv
`timescale 1ns/1ps
`default_nettype none

module decode_execute_core_properties (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       instr_valid_i,
  input  logic                       flush_i,
  input  cpu_isa_pkg::instruction_t  instr_i,
  input  cpu_ctrl_pkg::wb_result_t   result_i,
  input  cpu_ctrl_pkg::flags_t       flags_i
);

  import cpu_isa_pkg::*;

  // no result right after reset.
  reset_clears_result: assert property (@(posedge clk_i) reset_i |=> !result_i.valid)
    else $error("result valid in the cycle after reset");

  // nop and unused encodings retire without a result.
  accepted_gives_result: assert property (@(posedge clk_i) disable iff (reset_i)
    (instr_valid_i && !flush_i && instr_i.opcode != OP_NOP && instr_i.opcode <= OP_CMP)
    |-> ##2 result_i.valid)
    else $error("accepted instruction produced no result two cycles later");

  // nop, movi and killed slots leave the flags alone.
  flags_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    !(instr_valid_i && !flush_i && instr_i.opcode != OP_NOP
      && instr_i.opcode != OP_MOVI && instr_i.opcode <= OP_CMP)
    |=> ##1 $stable(flags_i))
    else $error("flags changed without a flag update");

endmodule

bind decode_execute_core decode_execute_core_properties u_properties (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .instr_valid_i (instr_valid_i),
  .flush_i       (flush_i),
  .instr_i       (instr_i),
  .result_i      (result_o),
  .flags_i       (flags_o)
);

`default_nettype wire

// File: test/decode_execute_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module decode_execute_core_tb;

  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;

  typedef logic [`CPU_WORD-1:0] word_t;

  typedef struct packed {
    instruction_t                instr;
    word_t                       pc;
    logic                        flush;
    logic                        exp_valid;
    logic                        exp_rf_write;
    logic [`CPU_ADDR_WIDTH-1:0]  exp_dest;
    word_t                       exp_data;
    flags_t                      exp_flags;
  } row_t;

  localparam int TIMEOUT_CYCLES = 50;
  localparam int RANDOM_ROUNDS  = 8;

  logic          clk;
  logic          reset;
  logic          instr_valid;
  instruction_t  instr;
  word_t         pc;
  logic          flush;
  wb_result_t    result;
  flags_t        flags;

  row_t   table_q[$];
  word_t  next_pc;
  int     checked_rows;
  int     seed;

  decode_execute_core dut (
    .clk_i         (clk),
    .reset_i       (reset),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .pc_i          (pc),
    .flush_i       (flush),
    .result_o      (result),
    .flags_o       (flags)
  );

  always #2 clk = ~clk;

  // ----------------------------------------------------------------------
  // instruction encoding and table building.
  // ----------------------------------------------------------------------
  function automatic instruction_t encode_reg_op(opcode_e op, logic [2:0] rd,
                                                 logic [2:0] rs1, logic [2:0] rs2,
                                                 logic [2:0] rs3);
    instruction_t word;
    word.opcode = op;
    word.rd     = rd;
    word.rs1    = rs1;
    word.tail   = {rs2, rs3};
    return word;
  endfunction

  function automatic instruction_t encode_addi(logic [2:0] rd, logic [2:0] rs1,
                                               logic [5:0] imm);
    instruction_t word;
    word.opcode = OP_ADDI;
    word.rd     = rd;
    word.rs1    = rs1;
    word.tail   = imm;
    return word;
  endfunction

  // top two value bits ride in rs1.
  function automatic instruction_t encode_movi(logic [2:0] rd, logic [7:0] value);
    instruction_t word;
    word.opcode = OP_MOVI;
    word.rd     = rd;
    word.rs1    = {1'b0, value[7:6]};
    word.tail   = value[5:0];
    return word;
  endfunction

  task automatic add_row(instruction_t row_instr, logic row_flush, logic exp_valid,
                         logic exp_rf_write, word_t exp_data, flags_t exp_flags);
    row_t row;
    row.instr        = row_instr;
    row.pc           = next_pc;
    row.flush        = row_flush;
    row.exp_valid    = exp_valid;
    row.exp_rf_write = exp_rf_write;
    row.exp_dest     = row_instr.rd;
    row.exp_data     = exp_data;
    row.exp_flags    = exp_flags;
    table_q.push_back(row);
    next_pc = next_pc + 16'd2;
  endtask

  // flags are written as {zero, negative, carry}.
  task automatic build_directed_rows();
    add_row(encode_movi(3'd0, 8'h11), 1'b0, 1'b1, 1'b1, 16'h0011, 3'b000);
    add_row(encode_movi(3'd1, 8'h22), 1'b0, 1'b1, 1'b1, 16'h0022, 3'b000);
    add_row(encode_movi(3'd2, 8'h33), 1'b0, 1'b1, 1'b1, 16'h0033, 3'b000);
    add_row(encode_movi(3'd3, 8'h44), 1'b0, 1'b1, 1'b1, 16'h0044, 3'b000);
    add_row(encode_movi(3'd4, 8'h55), 1'b0, 1'b1, 1'b1, 16'h0055, 3'b000);
    add_row(encode_movi(3'd5, 8'hf0), 1'b0, 1'b1, 1'b1, 16'h00f0, 3'b000);
    add_row(encode_movi(3'd6, 8'h0f), 1'b0, 1'b1, 1'b1, 16'h000f, 3'b000);
    add_row(encode_movi(3'd7, 8'hff), 1'b0, 1'b1, 1'b1, 16'h00ff, 3'b000);
    // dependent chain, each op reads the result before it.
    add_row(encode_reg_op(OP_ADD, 3'd1, 3'd1, 3'd2, 3'd0), 1'b0, 1'b1, 1'b1, 16'h0055, 3'b000);
    add_row(encode_reg_op(OP_SUB, 3'd2, 3'd1, 3'd3, 3'd0), 1'b0, 1'b1, 1'b1, 16'h0011, 3'b000);
    add_row(encode_reg_op(OP_AND, 3'd3, 3'd2, 3'd4, 3'd0), 1'b0, 1'b1, 1'b1, 16'h0011, 3'b000);
    add_row(encode_reg_op(OP_OR, 3'd4, 3'd3, 3'd5, 3'd0), 1'b0, 1'b1, 1'b1, 16'h00f1, 3'b000);
    add_row(encode_reg_op(OP_XOR, 3'd5, 3'd4, 3'd6, 3'd0), 1'b0, 1'b1, 1'b1, 16'h00fe, 3'b000);
    // rs2 points at r0, so a wrong source gives 0x010f.
    add_row(encode_reg_op(OP_ADD3, 3'd6, 3'd5, 3'd0, 3'd7), 1'b0, 1'b1, 1'b1, 16'h01fd, 3'b000);
    add_row(encode_addi(3'd7, 3'd0, 6'b111101), 1'b0, 1'b1, 1'b1, 16'h000e, 3'b001);
    add_row(encode_addi(3'd0, 3'd0, 6'b100000), 1'b0, 1'b1, 1'b1, 16'hfff1, 3'b010);
    add_row(encode_reg_op(OP_ADD, 3'd1, 3'd0, 3'd6, 3'd0), 1'b0, 1'b1, 1'b1, 16'h01ee, 3'b001);
    add_row(encode_reg_op(OP_SUB, 3'd2, 3'd1, 3'd1, 3'd0), 1'b0, 1'b1, 1'b1, 16'h0000, 3'b100);
    add_row(encode_reg_op(OP_CMP, 3'd3, 3'd2, 3'd4, 3'd0), 1'b0, 1'b1, 1'b0, 16'hff0f, 3'b011);
    // killed movi must leave r3 at 0x0011.
    add_row(encode_movi(3'd3, 8'haa), 1'b1, 1'b0, 1'b0, 16'h0000, 3'b011);
    add_row(encode_reg_op(OP_OR, 3'd4, 3'd3, 3'd2, 3'd0), 1'b0, 1'b1, 1'b1, 16'h0011, 3'b000);
    add_row(encode_reg_op(OP_NOP, 3'd0, 3'd0, 3'd0, 3'd0), 1'b0, 1'b0, 1'b0, 16'h0000, 3'b000);
    add_row(encode_reg_op(OP_SUB, 3'd5, 3'd4, 3'd3, 3'd0), 1'b0, 1'b1, 1'b1, 16'h0000, 3'b100);
    add_row(encode_reg_op(OP_NOP, 3'd1, 3'd2, 3'd3, 3'd4), 1'b0, 1'b0, 1'b0, 16'h0000, 3'b100);
  endtask

  task automatic build_random_adds();
    logic [7:0]           a;
    logic [7:0]           b;
    logic [`CPU_WORD:0]   wide;
    flags_t               prev_flags;
    flags_t               sum_flags;
    for (int k = 0; k < RANDOM_ROUNDS; k++) begin
      a = 8'($random(seed));
      b = 8'($random(seed));
      prev_flags = table_q[$].exp_flags;
      add_row(encode_movi(3'd1, a), 1'b0, 1'b1, 1'b1, word_t'(a), prev_flags);
      add_row(encode_movi(3'd2, b), 1'b0, 1'b1, 1'b1, word_t'(b), prev_flags);
      wide = {9'b0, a} + {9'b0, b};
      sum_flags.zero     = (wide[`CPU_WORD-1:0] == '0);
      sum_flags.negative = wide[`CPU_WORD-1];
      sum_flags.carry    = wide[`CPU_WORD];
      add_row(encode_reg_op(OP_ADD, 3'd3, 3'd1, 3'd2, 3'd0), 1'b0, 1'b1, 1'b1,
              wide[`CPU_WORD-1:0], sum_flags);
    end
  endtask

  // ----------------------------------------------------------------------
  // failure reporting and checks.
  // ----------------------------------------------------------------------
  task automatic report_mismatch(string name, word_t got, word_t exp);
    $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    $display("TESTS FAILED");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic report_timeout(string what);
    $display("ERROR at %0t ns: timed out waiting for %s", $time, what);
    $display("TESTS FAILED");
    $fatal(1, "stopped on timeout");
  endtask

  task automatic check_value(string name, word_t got, word_t exp);
    assert (got === exp) else report_mismatch(name, got, exp);
  endtask

  task automatic check_row(row_t row);
    check_value("result_o.valid", word_t'(result.valid), word_t'(row.exp_valid));
    if (row.exp_valid) begin
      check_value("result_o.rf_write", word_t'(result.rf_write), word_t'(row.exp_rf_write));
      check_value("result_o.dest", word_t'(result.dest), word_t'(row.exp_dest));
      check_value("result_o.data", result.data, row.exp_data);
      check_value("result_o.pc", result.pc, row.pc);
    end
    check_value("flags_o", word_t'(flags), word_t'(row.exp_flags));
  endtask

  // ----------------------------------------------------------------------
  // drive, check and wait.
  // ----------------------------------------------------------------------
  task automatic drive_rows();
    foreach (table_q[i]) begin
      @(posedge clk);
      instr_valid <= 1'b1;
      instr       <= table_q[i].instr;
      pc          <= table_q[i].pc;
      flush       <= table_q[i].flush;
    end
    @(posedge clk);
    instr_valid <= 1'b0;
    instr       <= '0;
    flush       <= 1'b0;
  endtask

  // row i lands in result two edges after it is driven.
  task automatic check_rows();
    repeat (2) @(posedge clk);
    for (int i = 0; i < table_q.size(); i++) begin
      @(posedge clk);
      @(negedge clk);
      check_row(table_q[i]);
      checked_rows++;
    end
  endtask

  task automatic wait_for_reset_release();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (result.valid !== 1'b0 || flags !== 3'b000) begin
      if (cycles >= TIMEOUT_CYCLES) report_timeout("outputs to clear after reset");
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic wait_for_drain();
    int cycles;
    cycles = 0;
    while (checked_rows < table_q.size()) begin
      if (cycles >= TIMEOUT_CYCLES) report_timeout("the last results to be checked");
      @(negedge clk);
      cycles++;
    end
  endtask

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    instr_valid  = 1'b0;
    instr        = '0;
    pc           = '0;
    flush        = 1'b0;
    seed         = 32'hfede_25e1;
    next_pc      = 16'h0100;
    checked_rows = 0;

    build_directed_rows();
    build_random_adds();

    repeat (10) @(posedge clk);
    reset <= 1'b0;
    wait_for_reset_release();

    fork
      check_rows();
    join_none
    drive_rows();
    wait_for_drain();

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: decode_execute_core.f
+incdir+rtl
rtl/cpu_isa_pkg.sv
rtl/cpu_ctrl_pkg.sv
rtl/instruction_decoder.sv
rtl/decode_execution_register.sv
rtl/register_file.sv
rtl/alu_execute.sv
rtl/decode_execute_core.sv
test/decode_execute_core_properties.sv
test/decode_execute_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the decode/execute testbench with Verilator, run it, and check the log.
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --top-module decode_execute_core_tb \
  -f decode_execute_core.f -o decode_execute_core_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/decode_execute_core_sim > sim.log 2>&1
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || exit 1
exit 0
